// ==== hdl/lc3_pkg.sv ====
package lc3_pkg;

    localparam int unsigned word_w = 16;
    localparam logic [word_w-1:0] reset_vector = 16'h3000;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ld   = 4'b0010,
        op_st   = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_not  = 4'b1001,
        op_jmp  = 4'b1100,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } opcode_e;

    typedef enum logic [4:0] {
        s_fetch1, s_fetch2, s_fetch3, s_fetch4,
        s_decode,
        s_alu, s_br, s_jmp, s_jsr1, s_jsr2, s_lea,
        s_ld1, s_ld2, s_ld3, s_ld4,
        s_st1, s_st2, s_st3,
        s_halt
    } state_e;

    // bus_none drives zero onto the bus.
    typedef enum logic [2:0] {bus_none, bus_pc, bus_mdr, bus_alu, bus_addr} bus_src_e;

    typedef enum logic [1:0] {pc_inc, pc_addr, pc_bus} pc_src_e;

    typedef enum logic [1:0] {
        addr2_off11 = 2'b00,
        addr2_off9  = 2'b01,
        addr2_off6  = 2'b10,
        addr2_zero  = 2'b11
    } addr2_sel_e;

    typedef enum logic [1:0] {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_pass = 2'b10,
        alu_not  = 2'b11
    } alu_op_e;

endpackage

// ==== hdl/lc3_bus_mux.sv ====
`timescale 1ns/1ps

module lc3_bus_mux (
    input  logic [lc3_pkg::word_w-1:0] ir,
    input  logic [lc3_pkg::word_w-1:0] pc,
    input  logic [lc3_pkg::word_w-1:0] mdr,
    input  logic [lc3_pkg::word_w-1:0] alu_out,
    input  logic [lc3_pkg::word_w-1:0] sr1_out,
    input  lc3_pkg::bus_src_e          bus_src,
    input  lc3_pkg::pc_src_e           pc_src,
    input  logic                       addr1_is_pc,
    input  lc3_pkg::addr2_sel_e        addr2_sel,
    output logic [lc3_pkg::word_w-1:0] bus,
    output logic [lc3_pkg::word_w-1:0] addr_sum,
    output logic [lc3_pkg::word_w-1:0] pc_in
);

    logic [lc3_pkg::word_w-1:0] off11_sext;
    logic [lc3_pkg::word_w-1:0] off9_sext;
    logic [lc3_pkg::word_w-1:0] off6_sext;
    logic [lc3_pkg::word_w-1:0] addr1;
    logic [lc3_pkg::word_w-1:0] addr2;

    assign off11_sext = {{5{ir[10]}}, ir[10:0]};  // jsr.
    assign off9_sext  = {{7{ir[8]}}, ir[8:0]};    // br, ld, st, lea.
    assign off6_sext  = {{10{ir[5]}}, ir[5:0]};

    // pc here already points past the current instruction.
    assign addr1 = addr1_is_pc ? pc : sr1_out;

    always_comb
    begin
        case (addr2_sel)
            lc3_pkg::addr2_off11: addr2 = off11_sext;
            lc3_pkg::addr2_off9:  addr2 = off9_sext;
            lc3_pkg::addr2_off6:  addr2 = off6_sext;
            default:              addr2 = '0;
        endcase
    end

    assign addr_sum = addr1 + addr2;

    always_comb
    begin
        case (pc_src)
            lc3_pkg::pc_addr: pc_in = addr_sum;
            lc3_pkg::pc_bus:  pc_in = bus;
            default:          pc_in = pc + 16'd1;
        endcase
    end

    // one source at a time on the shared bus.
    always_comb
    begin
        case (bus_src)
            lc3_pkg::bus_pc:   bus = pc;
            lc3_pkg::bus_mdr:  bus = mdr;
            lc3_pkg::bus_alu:  bus = alu_out;
            lc3_pkg::bus_addr: bus = addr_sum;
            default:           bus = '0;
        endcase
    end

endmodule

// ==== hdl/lc3_reg_file.sv ====
`timescale 1ns/1ps

module lc3_reg_file (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [lc3_pkg::word_w-1:0] ir,
    input  logic [lc3_pkg::word_w-1:0] bus,
    input  logic                       ld_reg,
    input  logic                       dr_is_r7,
    input  logic                       sr1_from_dst,
    output logic [lc3_pkg::word_w-1:0] sr1_out,
    output logic [lc3_pkg::word_w-1:0] sr2_out
);

    logic [lc3_pkg::word_w-1:0] regs [8];
    logic [2:0] dr;
    logic [2:0] sr1;
    logic [7:0] wr_en;

    assign dr  = dr_is_r7 ? 3'd7 : ir[11:9];  // r7 is the jsr link.
    assign sr1 = sr1_from_dst ? ir[11:9] : ir[8:6];  // st reads its source from [11:9].

    // one-hot write decode.
    always_comb
    begin
        wr_en = '0;
        if (ld_reg)
            wr_en[dr] = 1'b1;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < 8; i++)
                if (wr_en[i])
                    regs[i] <= bus;
        end
    end

    assign sr1_out = regs[sr1];
    assign sr2_out = regs[ir[2:0]];

endmodule

// ==== hdl/lc3_alu.sv ====
`timescale 1ns/1ps

module lc3_alu (
    input  logic [lc3_pkg::word_w-1:0] ir,
    input  logic [lc3_pkg::word_w-1:0] sr1_out,
    input  logic [lc3_pkg::word_w-1:0] sr2_out,
    input  lc3_pkg::alu_op_e           alu_op,
    output logic [lc3_pkg::word_w-1:0] alu_out
);

    logic [lc3_pkg::word_w-1:0] imm5_sext;
    logic [lc3_pkg::word_w-1:0] op_b;

    assign imm5_sext = {{11{ir[4]}}, ir[4:0]};

    // ir[5] picks the immediate form of add and and.
    assign op_b = ir[5] ? imm5_sext : sr2_out;

    always_comb
    begin
        case (alu_op)
            lc3_pkg::alu_add: alu_out = sr1_out + op_b;  // wraps at 16 bits.
            lc3_pkg::alu_and: alu_out = sr1_out & op_b;
            lc3_pkg::alu_not: alu_out = ~sr1_out;
            default:          alu_out = sr1_out;
        endcase
    end

endmodule

// ==== hdl/lc3_cond_codes.sv ====
`timescale 1ns/1ps

module lc3_cond_codes (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [lc3_pkg::word_w-1:0] bus,
    input  logic [lc3_pkg::word_w-1:0] ir,
    input  logic                       ld_cc,
    input  logic                       ld_ben,
    output logic                       ben
);

    logic [2:0] nzp_in;
    logic [2:0] nzp;
    logic       ben_in;

    always_comb
    begin
        if (bus == '0)
            nzp_in = 3'b010;
        else if (bus[lc3_pkg::word_w-1])
            nzp_in = 3'b100;
        else
            nzp_in = 3'b001;
    end

    assign ben_in = |(nzp & ir[11:9]);  // mask from the br instruction.

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            nzp <= '0;
            ben <= 1'b0;
        end
        else
        begin
            if (ld_cc)
                nzp <= nzp_in;
            if (ld_ben)
                ben <= ben_in;
        end
    end

endmodule

// ==== hdl/lc3_control.sv ====
`timescale 1ns/1ps

module lc3_control (
    input  logic                 clk,
    input  logic                 arst_n,
    input  lc3_pkg::opcode_e     opcode,
    input  logic                 ben,
    output logic                 ld_mar,
    output logic                 ld_mdr,
    output logic                 ld_ir,
    output logic                 ld_pc,
    output logic                 ld_reg,
    output logic                 ld_cc,
    output logic                 ld_ben,
    output lc3_pkg::bus_src_e    bus_src,
    output lc3_pkg::pc_src_e     pc_src,
    output logic                 mdr_from_mem,
    output logic                 dr_is_r7,
    output logic                 sr1_from_dst,
    output logic                 addr1_is_pc,
    output lc3_pkg::addr2_sel_e  addr2_sel,
    output lc3_pkg::alu_op_e     alu_op,
    output logic                 mem_en,
    output logic                 mem_we,
    output logic                 halted
);

    lc3_pkg::state_e state;
    lc3_pkg::state_e state_nxt;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= lc3_pkg::s_fetch1;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        case (state)
            lc3_pkg::s_fetch1: state_nxt = lc3_pkg::s_fetch2;
            lc3_pkg::s_fetch2: state_nxt = lc3_pkg::s_fetch3;
            lc3_pkg::s_fetch3: state_nxt = lc3_pkg::s_fetch4;
            lc3_pkg::s_fetch4: state_nxt = lc3_pkg::s_decode;
            lc3_pkg::s_decode:
            begin
                case (opcode)
                    lc3_pkg::op_add,
                    lc3_pkg::op_and,
                    lc3_pkg::op_not:  state_nxt = lc3_pkg::s_alu;
                    lc3_pkg::op_br:   state_nxt = lc3_pkg::s_br;
                    lc3_pkg::op_jmp:  state_nxt = lc3_pkg::s_jmp;
                    lc3_pkg::op_jsr:  state_nxt = lc3_pkg::s_jsr1;
                    lc3_pkg::op_lea:  state_nxt = lc3_pkg::s_lea;
                    lc3_pkg::op_ld:   state_nxt = lc3_pkg::s_ld1;
                    lc3_pkg::op_st:   state_nxt = lc3_pkg::s_st1;
                    lc3_pkg::op_trap: state_nxt = lc3_pkg::s_halt;
                    default:          state_nxt = lc3_pkg::s_halt;  // unsupported opcode.
                endcase
            end
            lc3_pkg::s_jsr1:   state_nxt = lc3_pkg::s_jsr2;
            lc3_pkg::s_ld1:    state_nxt = lc3_pkg::s_ld2;
            lc3_pkg::s_ld2:    state_nxt = lc3_pkg::s_ld3;
            lc3_pkg::s_ld3:    state_nxt = lc3_pkg::s_ld4;
            lc3_pkg::s_st1:    state_nxt = lc3_pkg::s_st2;
            lc3_pkg::s_st2:    state_nxt = lc3_pkg::s_st3;
            lc3_pkg::s_halt:   state_nxt = lc3_pkg::s_halt;
            default:           state_nxt = lc3_pkg::s_fetch1;
        endcase
    end

    always_comb
    begin
        ld_mar       = 1'b0;
        ld_mdr       = 1'b0;
        ld_ir        = 1'b0;
        ld_pc        = 1'b0;
        ld_reg       = 1'b0;
        ld_cc        = 1'b0;
        ld_ben       = 1'b0;
        bus_src      = lc3_pkg::bus_none;
        pc_src       = lc3_pkg::pc_inc;
        mdr_from_mem = 1'b0;
        dr_is_r7     = 1'b0;
        sr1_from_dst = 1'b0;
        addr1_is_pc  = 1'b0;
        addr2_sel    = lc3_pkg::addr2_zero;
        alu_op       = lc3_pkg::alu_pass;
        mem_en       = 1'b0;
        mem_we       = 1'b0;
        halted       = 1'b0;
        case (state)
            lc3_pkg::s_fetch1:
            begin
                bus_src = lc3_pkg::bus_pc;
                ld_mar  = 1'b1;
                ld_pc   = 1'b1;  // pc + 1.
            end
            lc3_pkg::s_fetch2, lc3_pkg::s_ld2:
                mem_en = 1'b1;
            lc3_pkg::s_fetch3, lc3_pkg::s_ld3:
            begin
                mdr_from_mem = 1'b1;
                ld_mdr       = 1'b1;
            end
            lc3_pkg::s_fetch4:
                ld_ir = 1'b1;
            lc3_pkg::s_decode:
                ld_ben = 1'b1;
            lc3_pkg::s_alu:
            begin
                case (opcode)
                    lc3_pkg::op_and: alu_op = lc3_pkg::alu_and;
                    lc3_pkg::op_not: alu_op = lc3_pkg::alu_not;
                    default:         alu_op = lc3_pkg::alu_add;
                endcase
                bus_src = lc3_pkg::bus_alu;
                ld_reg  = 1'b1;
                ld_cc   = 1'b1;
            end
            lc3_pkg::s_br:
            begin
                addr1_is_pc = 1'b1;
                addr2_sel   = lc3_pkg::addr2_off9;
                pc_src      = lc3_pkg::pc_addr;
                ld_pc       = ben;
            end
            lc3_pkg::s_jmp:
            begin
                bus_src = lc3_pkg::bus_alu;  // base register passes through the alu.
                pc_src  = lc3_pkg::pc_bus;
                ld_pc   = 1'b1;
            end
            lc3_pkg::s_jsr1:
            begin
                bus_src  = lc3_pkg::bus_pc;
                dr_is_r7 = 1'b1;
                ld_reg   = 1'b1;
            end
            lc3_pkg::s_jsr2:
            begin
                addr1_is_pc = 1'b1;
                addr2_sel   = lc3_pkg::addr2_off11;
                pc_src      = lc3_pkg::pc_addr;
                ld_pc       = 1'b1;
            end
            lc3_pkg::s_lea:
            begin
                addr1_is_pc = 1'b1;
                addr2_sel   = lc3_pkg::addr2_off9;
                bus_src     = lc3_pkg::bus_addr;
                ld_reg      = 1'b1;
                ld_cc       = 1'b1;
            end
            lc3_pkg::s_ld1, lc3_pkg::s_st1:
            begin
                addr1_is_pc = 1'b1;
                addr2_sel   = lc3_pkg::addr2_off9;
                bus_src     = lc3_pkg::bus_addr;
                ld_mar      = 1'b1;
            end
            lc3_pkg::s_ld4:
            begin
                bus_src = lc3_pkg::bus_mdr;
                ld_reg  = 1'b1;
                ld_cc   = 1'b1;
            end
            lc3_pkg::s_st2:
            begin
                sr1_from_dst = 1'b1;
                bus_src      = lc3_pkg::bus_alu;
                ld_mdr       = 1'b1;
            end
            lc3_pkg::s_st3:
            begin
                mem_en = 1'b1;
                mem_we = 1'b1;
            end
            lc3_pkg::s_halt:
                halted = 1'b1;
            default:
                halted = 1'b0;
        endcase
    end

endmodule

// ==== hdl/lc3_core.sv ====
`timescale 1ns/1ps

module lc3_core (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [lc3_pkg::word_w-1:0] mem_rdata,
    output logic [lc3_pkg::word_w-1:0] mem_addr,
    output logic [lc3_pkg::word_w-1:0] mem_wdata,
    output logic                       mem_en,
    output logic                       mem_we,
    output logic                       halted
);

    logic [lc3_pkg::word_w-1:0] pc;
    logic [lc3_pkg::word_w-1:0] ir;
    logic [lc3_pkg::word_w-1:0] mar;
    logic [lc3_pkg::word_w-1:0] mdr;
    logic [lc3_pkg::word_w-1:0] mdr_in;
    logic [lc3_pkg::word_w-1:0] bus;
    logic [lc3_pkg::word_w-1:0] addr_sum;
    logic [lc3_pkg::word_w-1:0] pc_in;
    logic [lc3_pkg::word_w-1:0] alu_out;
    logic [lc3_pkg::word_w-1:0] sr1_out;
    logic [lc3_pkg::word_w-1:0] sr2_out;

    logic ld_mar, ld_mdr, ld_ir, ld_pc, ld_reg, ld_cc, ld_ben;
    logic mdr_from_mem, dr_is_r7, sr1_from_dst, addr1_is_pc, ben;

    lc3_pkg::bus_src_e   bus_src;
    lc3_pkg::pc_src_e    pc_src;
    lc3_pkg::addr2_sel_e addr2_sel;
    lc3_pkg::alu_op_e    alu_op;

    assign mdr_in = mdr_from_mem ? mem_rdata : bus;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc <= lc3_pkg::reset_vector;
            ir <= '0;
        end
        else
        begin
            if (ld_pc)
                pc <= pc_in;
            if (ld_ir)
                ir <= mdr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ld_mar)
            mar <= bus;
        if (ld_mdr)
            mdr <= mdr_in;
    end

    assign mem_addr  = mar;
    assign mem_wdata = mdr;

    lc3_control lc3_control_i (
        .clk, .arst_n,
        .opcode       (lc3_pkg::opcode_e'(ir[15:12])),
        .ben,
        .ld_mar, .ld_mdr, .ld_ir, .ld_pc, .ld_reg, .ld_cc, .ld_ben,
        .bus_src, .pc_src, .mdr_from_mem, .dr_is_r7, .sr1_from_dst,
        .addr1_is_pc, .addr2_sel, .alu_op,
        .mem_en, .mem_we, .halted
    );

    lc3_bus_mux lc3_bus_mux_i (
        .ir, .pc, .mdr, .alu_out, .sr1_out,
        .bus_src, .pc_src, .addr1_is_pc, .addr2_sel,
        .bus, .addr_sum, .pc_in
    );

    lc3_reg_file lc3_reg_file_i (
        .clk, .arst_n, .ir, .bus, .ld_reg, .dr_is_r7, .sr1_from_dst,
        .sr1_out, .sr2_out
    );

    lc3_alu lc3_alu_i (.ir, .sr1_out, .sr2_out, .alu_op, .alu_out);

    lc3_cond_codes lc3_cond_codes_i (.clk, .arst_n, .bus, .ir, .ld_cc, .ld_ben, .ben);

endmodule

// ==== bench/lc3_props.sv ====
`timescale 1ns/1ps

module lc3_props (
    input logic clk,
    input logic arst_n,
    input logic mem_en,
    input logic mem_we,
    input logic halted
);

    we_needs_en: assert property (@(posedge clk) disable iff (!arst_n) mem_we |-> mem_en)
        else $error("mem_we high without mem_en");

    en_single_cycle: assert property (@(posedge clk) disable iff (!arst_n) mem_en |=> !mem_en)
        else $error("mem_en high for two cycles in a row");

    // s_halt is only left through reset.
    halt_is_final: assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> halted && !mem_en)
        else $error("halted fell or memory was accessed after halt");

    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !mem_en && !halted)
        else $error("mem_en or halted high during reset");

endmodule

bind lc3_core lc3_props lc3_props_i (
    .clk    (clk),
    .arst_n (arst_n),
    .mem_en (mem_en),
    .mem_we (mem_we),
    .halted (halted)
);

// ==== bench/lc3_tb.sv ====
`timescale 1ns/1ps

module lc3_tb;

    localparam int insn_total = 67;  // instructions executed over all tests.
    localparam int clk_period = 20;

    logic        clk;
    logic        arst_n;
    logic [15:0] mem_rdata;
    logic [15:0] mem_addr;
    logic [15:0] mem_wdata;
    logic        mem_en;
    logic        mem_we;
    logic        halted;

    logic [15:0] mem [65536];
    logic [15:0] st_addr [$];
    logic [15:0] st_data [$];
    int          access_count;
    logic [15:0] first_addr;
    logic        first_we;
    logic        first_halted;
    logic [15:0] load_ptr;

    lc3_core lc3_core_i (
        .clk, .arst_n, .mem_rdata, .mem_addr, .mem_wdata, .mem_en, .mem_we, .halted
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // memory answers on the falling edge and holds read data until the next read.
    initial
    begin
        mem_rdata = '0;
        forever
        begin
            @(negedge clk);
            if (mem_en)
            begin
                if (access_count == 0)
                begin
                    first_addr   = mem_addr;
                    first_we     = mem_we;
                    first_halted = halted;
                end
                access_count++;
                if (mem_we)
                begin
                    mem[mem_addr] = mem_wdata;
                    st_addr.push_back(mem_addr);
                    st_data.push_back(mem_wdata);
                end
                else
                    mem_rdata = mem[mem_addr];
            end
        end
    end

    initial
    begin
        #((insn_total * 12 + 300) * clk_period);
        report_failure("timeout, the core did not halt in time");
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        assert (got === exp)
        else report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(input int exp);
        assert (st_addr.size() == exp)
        else report_failure($sformatf("mismatch store count: got %h expected %h",
                                      st_addr.size(), exp));
    endtask

    task automatic check_store(input int idx, input logic [15:0] exp_addr,
                               input logic [15:0] exp_data);
        check_word($sformatf("mem_addr of store %0d", idx), st_addr[idx], exp_addr);
        check_word($sformatf("mem_wdata of store %0d", idx), st_data[idx], exp_data);
    endtask

    function automatic logic [15:0] sign_extend5(input logic [4:0] v);
        return {{11{v[4]}}, v};
    endfunction

    function automatic logic [15:0] sign_extend9(input logic [8:0] v);
        return {{7{v[8]}}, v};
    endfunction

    function automatic logic [15:0] encode_regs(input logic [3:0] op, input logic [2:0] a,
                                                input logic [2:0] b, input logic [5:0] low);
        return {op, a, b, low};
    endfunction

    // the offset counts from the word after load_ptr.
    function automatic logic [15:0] encode_rel(input logic [3:0] op, input logic [2:0] a,
                                               input logic [15:0] target);
        logic [15:0] off;
        off = target - load_ptr - 16'd1;
        return {op, a, off[8:0]};
    endfunction

    task automatic emit(input logic [15:0] word);
        mem[load_ptr] = word;
        load_ptr = load_ptr + 16'd1;
    endtask

    task automatic hold_reset_and_clear();
        @(negedge clk);
        arst_n = 1'b0;
        for (int a = 0; a < 65536; a++)
            mem[a] = 16'(a) ^ 16'h5a5a;
        st_addr.delete();
        st_data.delete();
        access_count = 0;
        load_ptr = lc3_pkg::reset_vector;
    endtask

    task automatic run_to_halt();
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        while (!halted)
            @(negedge clk);
    endtask

    task automatic test_reset_fetch();
        hold_reset_and_clear();
        emit(16'hf025);  // trap.
        run_to_halt();
        assert (access_count > 0 && first_we === 1'b0)
        else report_failure("first memory access after reset was not a read");
        check_word("mem_addr of first read", first_addr, lc3_pkg::reset_vector);
        assert (first_halted === 1'b0)
        else report_failure("halted was high at the first fetch");
    endtask

    task automatic test_arith();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res [5];
        logic [4:0]  imm_a;
        logic [4:0]  imm_b;
        a = 16'($urandom());
        b = 16'($urandom());
        imm_a = 5'($urandom());
        imm_b = 5'($urandom());
        res[0] = a + b;
        res[1] = a + sign_extend5(imm_a);
        res[2] = a & b;
        res[3] = a & sign_extend5(imm_b);
        res[4] = ~a;
        hold_reset_and_clear();
        mem[16'h3060] = a;
        mem[16'h3061] = b;
        emit(encode_rel(lc3_pkg::op_ld, 3'd1, 16'h3060));
        emit(encode_rel(lc3_pkg::op_ld, 3'd2, 16'h3061));
        emit(encode_regs(lc3_pkg::op_add, 3'd3, 3'd1, 6'b000010));
        emit(encode_rel(lc3_pkg::op_st, 3'd3, 16'h3080));
        emit(encode_regs(lc3_pkg::op_add, 3'd3, 3'd1, {1'b1, imm_a}));
        emit(encode_rel(lc3_pkg::op_st, 3'd3, 16'h3081));
        emit(encode_regs(lc3_pkg::op_and, 3'd3, 3'd1, 6'b000010));
        emit(encode_rel(lc3_pkg::op_st, 3'd3, 16'h3082));
        emit(encode_regs(lc3_pkg::op_and, 3'd3, 3'd1, {1'b1, imm_b}));
        emit(encode_rel(lc3_pkg::op_st, 3'd3, 16'h3083));
        emit(encode_regs(lc3_pkg::op_not, 3'd3, 3'd1, 6'b111111));
        emit(encode_rel(lc3_pkg::op_st, 3'd3, 16'h3084));
        emit(16'hf025);
        run_to_halt();
        check_count(5);
        for (int i = 0; i < 5; i++)
            check_store(i, 16'h3080 + 16'(i), res[i]);
    endtask

    task automatic test_lea_ld();
        logic [8:0]  pos_off;
        logic [8:0]  neg_off;
        logic [15:0] target;
        logic [15:0] data;
        pos_off = 9'(16 + $urandom_range(84));  // target stays below the store area.
        neg_off = 9'(-(1 + $urandom_range(199)));
        target = lc3_pkg::reset_vector + 16'd1 + sign_extend9(pos_off);
        data = 16'($urandom());
        hold_reset_and_clear();
        mem[target] = data;
        emit({lc3_pkg::op_lea, 3'd4, pos_off});
        emit(encode_rel(lc3_pkg::op_st, 3'd4, 16'h3080));
        emit({lc3_pkg::op_lea, 3'd4, neg_off});
        emit(encode_rel(lc3_pkg::op_st, 3'd4, 16'h3081));
        emit(encode_rel(lc3_pkg::op_ld, 3'd5, target));
        emit(encode_rel(lc3_pkg::op_st, 3'd5, 16'h3082));
        emit(16'hf025);
        run_to_halt();
        check_count(3);
        check_store(0, 16'h3080, target);
        check_store(1, 16'h3081, lc3_pkg::reset_vector + 16'd3 + sign_extend9(neg_off));
        check_store(2, 16'h3082, data);
    endtask

    task automatic test_branches();
        logic [15:0] slot;
        logic [2:0]  cls;
        logic [15:0] expect_addr [$];
        hold_reset_and_clear();
        emit(encode_regs(lc3_pkg::op_and, 3'd0, 3'd0, 6'b100000));
        for (int c = 0; c < 3; c++)
        begin
            // r0 steps through -1, 0 and 1.
            if (c == 0)
                emit(encode_regs(lc3_pkg::op_add, 3'd0, 3'd0, 6'b111111));
            else
                emit(encode_regs(lc3_pkg::op_add, 3'd0, 3'd0, 6'b100001));
            cls = (c == 0) ? 3'b100 : (c == 1) ? 3'b010 : 3'b001;
            for (int m = 0; m < 8; m++)
            begin
                slot = 16'h3080 + 16'(c * 8 + m);
                emit(encode_rel(lc3_pkg::op_br, 3'(m), load_ptr + 16'd2));  // skips the marker.
                emit(encode_rel(lc3_pkg::op_st, 3'd0, slot));
                if ((3'(m) & cls) == 3'b000)
                    expect_addr.push_back(slot);
            end
        end
        emit(16'hf025);
        run_to_halt();
        check_count(expect_addr.size());
        foreach (expect_addr[i])
            check_word($sformatf("mem_addr of store %0d", i), st_addr[i], expect_addr[i]);
    endtask

    task automatic test_subroutine();
        int seen;
        hold_reset_and_clear();
        emit({lc3_pkg::op_jsr, 1'b1, 11'd15});  // subroutine at 0x3010.
        emit(encode_rel(lc3_pkg::op_st, 3'd7, 16'h3081));
        emit(16'hf025);
        load_ptr = 16'h3010;
        emit(encode_rel(lc3_pkg::op_st, 3'd7, 16'h3080));
        emit(encode_regs(lc3_pkg::op_jmp, 3'd0, 3'd7, 6'b000000));
        run_to_halt();
        check_count(2);
        check_store(0, 16'h3080, lc3_pkg::reset_vector + 16'd1);
        check_store(1, 16'h3081, lc3_pkg::reset_vector + 16'd1);
        seen = access_count;
        repeat (20) @(negedge clk);
        assert (halted && access_count == seen)
        else report_failure("memory was accessed or halted fell after trap");
    endtask

    initial
    begin
        arst_n = 1'b0;
        load_ptr = lc3_pkg::reset_vector;
        void'($urandom(57599));
        test_reset_fetch();
        test_arith();
        test_lea_ld();
        test_branches();
        test_subroutine();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/lc3_pkg.sv
hdl/lc3_bus_mux.sv
hdl/lc3_reg_file.sv
hdl/lc3_alu.sv
hdl/lc3_cond_codes.sv
hdl/lc3_control.sv
hdl/lc3_core.sv
bench/lc3_props.sv
bench/lc3_tb.sv

// ==== Makefile ====
# Verilator flow for the LC-3 core testbench.

TOP = lc3_tb

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o lc3_sim
	@out=$$(./obj_dir/lc3_sim); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

.PHONY: lint sim clean
